//--- design/cpu_cfg_pkg.sv
package cpu_cfg_pkg;

    // data and address width of the core
    localparam int xlen = 32;

    // boot ROM entry, first fetch after reset
    localparam logic [xlen-1:0] reset_vector = 32'hbfc00000;

    // general exception entry while BEV is set
    localparam logic [xlen-1:0] ex_vector = 32'hbfc00380;

    // reads the fetch path may keep in flight on the instruction bus
    localparam int max_outstanding = 2;

endpackage

//--- design/fetch_pkg.sv
package fetch_pkg;

    // branch feedback from decode, br is the top bit
    typedef struct packed {
        // a branch sits in decode
        logic                         br;
        // operands not ready, outcome not known yet
        logic                         br_stall;
        logic                         br_taken;
        logic [cpu_cfg_pkg::xlen-1:0] br_target;
    } br_bus_t;

    // cp0 cause.exccode values raised in fetch
    typedef enum logic [4:0] {
        no_ex = 5'h00,
        // address error on instruction load
        adel  = 5'h04
    } ex_code_t;

    // one fetched instruction on its way to decode
    typedef struct packed {
        logic                         pc_error;
        logic [cpu_cfg_pkg::xlen-1:0] bad_vaddr;
        ex_code_t                     ex_code;
        logic [cpu_cfg_pkg::xlen-1:0] inst;
        logic [cpu_cfg_pkg::xlen-1:0] pc;
    } fs_to_ds_t;

endpackage

//--- design/inst_req_if.sv
`timescale 1ns/1ps

interface inst_req_if;

    // request side, driven by the fetch stage
    logic                         req;
    logic [cpu_cfg_pkg::xlen-1:0] addr;
    // one-cycle pulse on exception or eret redirect
    logic                         flush;

    // acknowledge side, driven by the tracker
    logic                         addr_ok;
    logic                         data_ok;
    logic [cpu_cfg_pkg::xlen-1:0] rdata;

    modport stage (
        output req,
        output addr,
        output flush,
        input  addr_ok,
        input  data_ok,
        input  rdata
    );

    modport tracker (
        input  req,
        input  addr,
        input  flush,
        output addr_ok,
        output data_ok,
        output rdata
    );

endinterface

//--- design/pre_decode.sv
`timescale 1ns/1ps

module pre_decode (
    input  logic [cpu_cfg_pkg::xlen-1:0] fs_inst,
    output logic                         is_branch
);

    logic [5:0] opcode;
    logic [4:0] rt;
    logic [5:0] funct;

    assign opcode = fs_inst[31:26];
    assign rt     = fs_inst[20:16];
    assign funct  = fs_inst[5:0];

    always_comb begin
        is_branch = 1'b0;
        case (opcode)
            // special: jr, jalr
            6'b000000: begin
                is_branch = (funct == 6'b001000) || (funct == 6'b001001);
            end
            // regimm: bltz, bgez, bltzal, bgezal
            6'b000001: begin
                is_branch = (rt == 5'b00000) || (rt == 5'b00001) ||
                            (rt == 5'b10000) || (rt == 5'b10001);
            end
            // j, jal
            6'b000010,
            6'b000011: begin
                is_branch = 1'b1;
            end
            // beq, bne, blez, bgtz
            6'b000100,
            6'b000101,
            6'b000110,
            6'b000111: begin
                is_branch = 1'b1;
            end
            default: begin
                is_branch = 1'b0;
            end
        endcase
    end

endmodule

//--- design/if_stage.sv
`timescale 1ns/1ps

module if_stage #(
    parameter logic [cpu_cfg_pkg::xlen-1:0] RESET_VECTOR = cpu_cfg_pkg::reset_vector,
    parameter logic [cpu_cfg_pkg::xlen-1:0] EX_VECTOR    = cpu_cfg_pkg::ex_vector
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ds_allowin,
    input  fetch_pkg::br_bus_t           br_bus,
    output logic                         fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t         fs_to_ds_bus,
    inst_req_if.stage                    mem,
    input  logic                         eret,
    input  logic [cpu_cfg_pkg::xlen-1:0] cp0_epc,
    // bit 0 of the ds, es, ms, ws exception flags redirects fetch
    input  logic [3:0]                   ex_word
);

    localparam logic [cpu_cfg_pkg::xlen-1:0] word_step = 4;

    logic                         fs_valid;
    logic [cpu_cfg_pkg::xlen-1:0] fs_pc;
    logic                         inst_ready;
    logic [cpu_cfg_pkg::xlen-1:0] inst_buf;
    logic                         branch_seen;
    logic                         slot_seen;
    logic                         taken_hold;
    logic [cpu_cfg_pkg::xlen-1:0] target_hold;

    logic                         ex_redirect;
    logic                         redirect;
    logic                         resp_branch;
    logic                         cur_is_branch;
    logic                         have_inst;
    logic                         br_taken_now;
    logic                         slot_taken;
    logic [cpu_cfg_pkg::xlen-1:0] slot_target;
    logic [cpu_cfg_pkg::xlen-1:0] seq_pc;
    logic [cpu_cfg_pkg::xlen-1:0] nextpc;
    logic [cpu_cfg_pkg::xlen-1:0] fs_inst;
    logic                         fs_allowin;
    logic                         fetch_accept;
    logic                         pc_error;
    fetch_pkg::ex_code_t          ex_code;

    // only meaningful in a cycle with data_ok
    pre_decode u_pre_decode (
        .fs_inst   (mem.rdata),
        .is_branch (resp_branch)
    );

    assign ex_redirect = ex_word[0];
    assign redirect    = ex_redirect | eret;

    // live or held outcome of the branch whose slot sits in IF
    assign br_taken_now = br_bus.br & br_bus.br_taken & ~br_bus.br_stall;
    assign slot_taken   = taken_hold | br_taken_now;
    assign slot_target  = taken_hold ? target_hold : br_bus.br_target;

    // pre-IF next fetch address
    assign seq_pc = fs_pc + word_step;

    always_comb begin
        if (ex_redirect) begin
            nextpc = EX_VECTOR;
        end else if (eret) begin
            nextpc = cp0_epc;
        end else if (slot_seen && slot_taken) begin
            nextpc = slot_target;
        end else begin
            nextpc = seq_pc;
        end
    end

    // instruction at fs_pc is present once its response came back
    assign have_inst     = inst_ready | mem.data_ok;
    assign cur_is_branch = inst_ready ? branch_seen : resp_branch;
    assign fs_inst       = inst_ready ? inst_buf : mem.rdata;

    assign fs_allowin     = ~fs_valid | (have_inst & ds_allowin);
    assign fs_to_ds_valid = fs_valid & have_inst;

    // one read per IF slot
    assign mem.req      = fs_allowin & ~br_bus.br_stall & ~redirect;
    assign mem.addr     = {nextpc[cpu_cfg_pkg::xlen-1:2], 2'b00};
    assign mem.flush    = redirect;
    assign fetch_accept = mem.req & mem.addr_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid  <= 1'b0;
            // seq_pc then points at the reset vector
            fs_pc     <= RESET_VECTOR - word_step;
            slot_seen <= 1'b0;
        end else if (redirect) begin
            fs_valid  <= 1'b0;
            fs_pc     <= nextpc - word_step;
            slot_seen <= 1'b0;
        end else if (fetch_accept) begin
            fs_valid  <= 1'b1;
            fs_pc     <= nextpc;
            slot_seen <= have_inst & cur_is_branch;
        end else if (fs_to_ds_valid && ds_allowin) begin
            fs_valid  <= 1'b0;
        end
    end

    // response kept while decode is not ready
    always_ff @(posedge clk) begin
        if (reset) begin
            inst_ready  <= 1'b0;
            branch_seen <= 1'b0;
        end else if (redirect || fetch_accept) begin
            inst_ready  <= 1'b0;
        end else if (mem.data_ok) begin
            inst_ready  <= 1'b1;
            branch_seen <= resp_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.data_ok) begin
            inst_buf <= mem.rdata;
        end
    end

    // early target stays here until the fetch after the slot is sent
    always_ff @(posedge clk) begin
        if (reset) begin
            taken_hold <= 1'b0;
        end else if (redirect || (fetch_accept && slot_seen)) begin
            taken_hold <= 1'b0;
        end else if (br_taken_now) begin
            taken_hold <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (br_taken_now && !taken_hold) begin
            target_hold <= br_bus.br_target;
        end
    end

    // adel only when no older instruction is already excepting
    assign pc_error = ~|ex_word & (fs_pc[1:0] != 2'b00);
    assign ex_code  = pc_error ? fetch_pkg::adel : fetch_pkg::no_ex;

    always_comb begin
        fs_to_ds_bus.pc_error  = pc_error;
        fs_to_ds_bus.bad_vaddr = pc_error ? fs_pc : '0;
        fs_to_ds_bus.ex_code   = ex_code;
        fs_to_ds_bus.inst      = fs_inst;
        fs_to_ds_bus.pc        = fs_pc;
    end

    // a stalled instruction survives until decode takes it or a redirect
    a_hold_stable: assert property (
        @(posedge clk) disable iff (reset)
        (fs_to_ds_valid && !ds_allowin && !redirect) ##1 $stable(ex_word)
            |-> fs_to_ds_valid && $stable(fs_to_ds_bus)
    ) else $error("fs_to_ds_bus changed under backpressure");

endmodule

//--- design/inst_req_tracker.sv
`timescale 1ns/1ps

module inst_req_tracker #(
    parameter int MAX_OUTSTANDING = cpu_cfg_pkg::max_outstanding
) (
    input  logic                         clk,
    input  logic                         reset,
    inst_req_if.tracker                  core,
    output logic                         inst_sram_en,
    output logic                         inst_sram_wr,
    output logic [1:0]                   inst_sram_size,
    output logic [3:0]                   inst_sram_wen,
    output logic [cpu_cfg_pkg::xlen-1:0] inst_sram_addr,
    output logic [cpu_cfg_pkg::xlen-1:0] inst_sram_wdata,
    input  logic                         inst_sram_addr_ok,
    input  logic                         inst_sram_data_ok,
    input  logic [cpu_cfg_pkg::xlen-1:0] inst_sram_rdata
);

    localparam int cnt_w = $clog2(MAX_OUTSTANDING + 1);

    logic [cnt_w-1:0] pending;
    logic [cnt_w-1:0] drop_cnt;
    logic             room;
    logic             accept;
    logic             resp_drop;

    // request goes out only while there is room for its response
    assign room   = pending < cnt_w'(MAX_OUTSTANDING);
    assign accept = inst_sram_en & inst_sram_addr_ok;

    assign inst_sram_en   = core.req & room;
    assign inst_sram_addr = core.addr;
    assign core.addr_ok   = inst_sram_addr_ok & room;

    // responses of reads issued before a flush never reach the stage
    assign resp_drop    = drop_cnt != '0;
    assign core.data_ok = inst_sram_data_ok & ~resp_drop;
    assign core.rdata   = inst_sram_rdata;

    // read-only port, word sized
    assign inst_sram_wr    = 1'b0;
    assign inst_sram_size  = 2'b10;
    assign inst_sram_wen   = 4'h0;
    assign inst_sram_wdata = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= pending + cnt_w'(accept) - cnt_w'(inst_sram_data_ok);
        end
    end

    // everything still in flight at the flush is stale
    always_ff @(posedge clk) begin
        if (reset) begin
            drop_cnt <= '0;
        end else if (core.flush) begin
            drop_cnt <= pending - cnt_w'(inst_sram_data_ok);
        end else if (inst_sram_data_ok && resp_drop) begin
            drop_cnt <= drop_cnt - 1'b1;
        end
    end

    a_no_orphan_resp: assert property (
        @(posedge clk) disable iff (reset)
        inst_sram_data_ok |-> (pending != '0)
    ) else $error("data_ok with no read outstanding");

    a_pending_limit: assert property (
        @(posedge clk) disable iff (reset)
        pending <= cnt_w'(MAX_OUTSTANDING)
    ) else $error("outstanding reads above limit: %0d", pending);

endmodule

//--- design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter logic [cpu_cfg_pkg::xlen-1:0] RESET_VECTOR    = cpu_cfg_pkg::reset_vector,
    parameter logic [cpu_cfg_pkg::xlen-1:0] EX_VECTOR       = cpu_cfg_pkg::ex_vector,
    parameter int                           MAX_OUTSTANDING = cpu_cfg_pkg::max_outstanding
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ds_allowin,
    input  logic                         br,
    input  logic                         br_stall,
    input  logic                         br_taken,
    input  logic [cpu_cfg_pkg::xlen-1:0] br_target,
    input  logic                         eret,
    input  logic [cpu_cfg_pkg::xlen-1:0] cp0_epc,
    input  logic [3:0]                   ex_word,
    output logic                         fs_to_ds_valid,
    output logic [cpu_cfg_pkg::xlen-1:0] fs_pc,
    output logic [cpu_cfg_pkg::xlen-1:0] fs_inst,
    output logic [4:0]                   fs_ex_code,
    output logic [cpu_cfg_pkg::xlen-1:0] fs_bad_vaddr,
    output logic                         inst_sram_en,
    output logic                         inst_sram_wr,
    output logic [1:0]                   inst_sram_size,
    output logic [3:0]                   inst_sram_wen,
    output logic [cpu_cfg_pkg::xlen-1:0] inst_sram_addr,
    output logic [cpu_cfg_pkg::xlen-1:0] inst_sram_wdata,
    input  logic                         inst_sram_addr_ok,
    input  logic                         inst_sram_data_ok,
    input  logic [cpu_cfg_pkg::xlen-1:0] inst_sram_rdata
);

    fetch_pkg::br_bus_t   br_bus;
    fetch_pkg::fs_to_ds_t fs_to_ds_bus;

    inst_req_if req_bus ();

    assign br_bus.br        = br;
    assign br_bus.br_stall  = br_stall;
    assign br_bus.br_taken  = br_taken;
    assign br_bus.br_target = br_target;

    // pc_error is implied by a non-zero ex code here
    assign fs_pc        = fs_to_ds_bus.pc;
    assign fs_inst      = fs_to_ds_bus.inst;
    assign fs_ex_code   = fs_to_ds_bus.ex_code;
    assign fs_bad_vaddr = fs_to_ds_bus.bad_vaddr;

    if_stage #(
        .RESET_VECTOR (RESET_VECTOR),
        .EX_VECTOR    (EX_VECTOR)
    ) u_if_stage (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .mem            (req_bus.stage),
        .eret           (eret),
        .cp0_epc        (cp0_epc),
        .ex_word        (ex_word)
    );

    inst_req_tracker #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_tracker (
        .clk               (clk),
        .reset             (reset),
        .core              (req_bus.tracker),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wr      (inst_sram_wr),
        .inst_sram_size    (inst_sram_size),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_addr_ok (inst_sram_addr_ok),
        .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata   (inst_sram_rdata)
    );

endmodule

//--- verif/tb_fetch_checks.svh
`ifndef TB_FETCH_CHECKS_SVH
`define TB_FETCH_CHECKS_SVH

// mips branch and jump encodings including register jumps and link forms
function automatic bit is_branch_word(logic [cpu_cfg_pkg::xlen-1:0] w);
    case (w[31:26])
        6'b000000: return (w[5:0] == 6'b001000) || (w[5:0] == 6'b001001);
        6'b000001: return (w[20:16] == 5'b00000) || (w[20:16] == 5'b00001) ||
                          (w[20:16] == 5'b10000) || (w[20:16] == 5'b10001);
        6'b000010, 6'b000011, 6'b000100, 6'b000101, 6'b000110, 6'b000111: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// pc following a delivered instruction
function automatic logic [cpu_cfg_pkg::xlen-1:0] pc_after(
    logic [cpu_cfg_pkg::xlen-1:0] pc,
    bit                           was_slot,
    bit                           taken,
    logic [cpu_cfg_pkg::xlen-1:0] target
);
    if (was_slot && taken) begin
        return target;
    end
    return pc + 32'd4;
endfunction

task automatic check_pc(string name, logic [cpu_cfg_pkg::xlen-1:0] exp,
                        logic [cpu_cfg_pkg::xlen-1:0] act);
    if (exp !== act) begin
        pc_errors++;
        $display("error %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_inst(string name, logic [cpu_cfg_pkg::xlen-1:0] exp,
                          logic [cpu_cfg_pkg::xlen-1:0] act);
    if (exp !== act) begin
        inst_errors++;
        $display("error %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_ex_code(string name, fetch_pkg::ex_code_t exp, fetch_pkg::ex_code_t act);
    if (exp !== act) begin
        ex_errors++;
        $display("error %s: expected %h, actual %h", name, exp, act);
    end
endtask

// write side of the instruction bus, a plain word read
task automatic check_bus_attr(string name, logic [cpu_cfg_pkg::xlen-1:0] exp,
                              logic [cpu_cfg_pkg::xlen-1:0] act);
    if (exp !== act) begin
        bus_errors++;
        $display("error %s: expected %h, actual %h", name, exp, act);
    end
endtask

`endif

//--- verif/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    localparam logic [31:0] reset_vector = cpu_cfg_pkg::reset_vector;
    localparam logic [31:0] ex_vector    = cpu_cfg_pkg::ex_vector;
    localparam int max_outstanding = cpu_cfg_pkg::max_outstanding;
    localparam int timeout_cycles  = 2000;
    localparam int target_count    = 3000;

    logic        clk, reset, ds_allowin, br, br_stall, br_taken, eret;
    logic [31:0] br_target, cp0_epc;
    logic [3:0]  ex_word;
    logic        fs_to_ds_valid;
    logic [31:0] fs_pc, fs_inst, fs_bad_vaddr;
    logic [4:0]  fs_ex_code;
    logic        inst_sram_en, inst_sram_wr, inst_sram_addr_ok, inst_sram_data_ok;
    logic [1:0]  inst_sram_size;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr, inst_sram_wdata, inst_sram_rdata;

    // instruction table filled on first read of an address
    logic [31:0] mem_words [logic [31:0]];
    logic [31:0] req_addr_q [$];
    int          req_due_q [$];
    int          cycle, in_flight, delivered, idle_cycles;
    int          pc_errors, inst_errors, ex_errors, bus_errors, other_errors;

    // decode side model
    logic [31:0] exp_pc, br_target_m;
    bit          in_slot, br_active, br_taken_m;
    string       next_tag;

    fetch_top #(
        .RESET_VECTOR (reset_vector), .EX_VECTOR (ex_vector), .MAX_OUTSTANDING (max_outstanding)
    ) u_dut (
        .clk (clk), .reset (reset), .ds_allowin (ds_allowin),
        .br (br), .br_stall (br_stall), .br_taken (br_taken), .br_target (br_target),
        .eret (eret), .cp0_epc (cp0_epc), .ex_word (ex_word),
        .fs_to_ds_valid (fs_to_ds_valid), .fs_pc (fs_pc), .fs_inst (fs_inst),
        .fs_ex_code (fs_ex_code), .fs_bad_vaddr (fs_bad_vaddr),
        .inst_sram_en (inst_sram_en), .inst_sram_wr (inst_sram_wr),
        .inst_sram_size (inst_sram_size), .inst_sram_wen (inst_sram_wen),
        .inst_sram_addr (inst_sram_addr), .inst_sram_wdata (inst_sram_wdata),
        .inst_sram_addr_ok (inst_sram_addr_ok), .inst_sram_data_ok (inst_sram_data_ok),
        .inst_sram_rdata (inst_sram_rdata)
    );

    always #20 clk = ~clk;

    `include "tb_fetch_checks.svh"

    function automatic logic [31:0] aligned_target();
        return reset_vector + (($urandom % 1024) << 2);
    endfunction

    // a few taken targets land off word boundaries
    function automatic logic [31:0] random_target();
        logic [31:0] t;
        t = aligned_target();
        if ($urandom % 16 == 0) begin
            t = t + 32'd1 + ($urandom % 3);
        end
        return t;
    endfunction

    // every branch and jump form, picked by the top two random bits
    function automatic logic [31:0] branch_word(logic [31:0] r);
        case (r[31:30])
            // beq, bne, blez, bgtz
            2'd0: return {4'b0001, r[27:0]};
            // j, jal
            2'd1: return {5'b00001, r[26:0]};
            // jr, jalr
            2'd2: return {6'b000000, r[25:6], 5'b00100, r[0]};
            // bltz, bgez, bltzal, bgezal
            default: return {6'b000001, r[25:21], r[20], 3'b000, r[16], r[15:0]};
        endcase
    endfunction

    // no branch right next to another so no branch sits in a delay slot
    function automatic logic [31:0] word_at(logic [31:0] a);
        logic [31:0] w;
        bit          near_branch;
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        near_branch = (mem_words.exists(a - 4) && is_branch_word(mem_words[a - 4])) ||
                      (mem_words.exists(a + 4) && is_branch_word(mem_words[a + 4]));
        if (!near_branch && ($urandom % 6 == 0)) begin
            w = branch_word($urandom);
        end else begin
            w = $urandom;
            if (is_branch_word(w)) begin
                w[31:26] = 6'b001001;
            end
        end
        mem_words[a] = w;
        return w;
    endfunction

    task automatic take_delivery();
        logic [31:0] word;
        bit          misaligned;
        word = word_at({exp_pc[31:2], 2'b00});
        misaligned = exp_pc[1:0] != 2'b00;
        check_pc(next_tag, exp_pc, fs_pc);
        check_inst(next_tag, word, fs_inst);
        check_ex_code(next_tag, misaligned ? fetch_pkg::adel : fetch_pkg::no_ex,
                      fetch_pkg::ex_code_t'(fs_ex_code));
        check_pc({next_tag, "_bad_vaddr"}, misaligned ? exp_pc : 32'h0, fs_bad_vaddr);
        if (in_slot) begin
            exp_pc    = pc_after(exp_pc, 1'b1, br_taken_m, br_target_m);
            in_slot   = 1'b0;
            br_active = 1'b0;
            next_tag  = br_taken_m ? "branch_target" : "not_taken";
        end else if (is_branch_word(word)) begin
            exp_pc      = pc_after(exp_pc, 1'b0, 1'b0, 32'h0);
            in_slot     = 1'b1;
            br_active   = 1'b1;
            br_taken_m  = ($urandom % 2) == 1;
            br_target_m = random_target();
            next_tag    = "delay_slot";
        end else begin
            exp_pc   = pc_after(exp_pc, 1'b0, 1'b0, 32'h0);
            next_tag = "sequential";
        end
        delivered++;
        idle_cycles = 0;
    endtask

    // late in the cycle when everything driven has settled
    task automatic sample_cycle();
        if (inst_sram_en && inst_sram_addr_ok) begin
            void'(word_at(inst_sram_addr));
            req_addr_q.push_back(inst_sram_addr);
            req_due_q.push_back(cycle + 1 + ($urandom % 5));
            in_flight++;
        end
        if (inst_sram_en) begin
            check_bus_attr("sram_wr", 32'h0, 32'(inst_sram_wr));
            check_bus_attr("sram_size", 32'h2, 32'(inst_sram_size));
            check_bus_attr("sram_wen", 32'h0, 32'(inst_sram_wen));
            check_bus_attr("sram_wdata", 32'h0, inst_sram_wdata);
        end
        if (inst_sram_data_ok) begin
            void'(req_addr_q.pop_front());
            void'(req_due_q.pop_front());
            in_flight--;
        end
        if (in_flight > max_outstanding) begin
            other_errors++;
            $display("more reads in flight than allowed: %0d", in_flight);
        end
        idle_cycles++;
        if (ex_word[0] || eret) begin
            exp_pc    = ex_word[0] ? ex_vector : cp0_epc;
            next_tag  = ex_word[0] ? "ex_vector" : "eret_epc";
            in_slot   = 1'b0;
            br_active = 1'b0;
        end else if (fs_to_ds_valid && ds_allowin) begin
            take_delivery();
        end
    endtask

    task automatic drive_inputs();
        bit redirect_now;
        cycle++;
        eret    = 1'b0;
        ex_word = 4'h0;
        redirect_now = ($urandom % 64) == 0;
        if (redirect_now) begin
            if ($urandom % 2 == 0) begin
                ex_word = 4'h1;
            end else begin
                eret    = 1'b1;
                cp0_epc = aligned_target();
            end
        end
        br        = br_active && !redirect_now;
        br_stall  = br && ($urandom % 4 == 0);
        br_taken  = br && br_taken_m;
        br_target = br_target_m;
        // decode holds the slot out while the branch waits on operands
        ds_allowin = ($urandom % 4 != 0) && !br_stall && !redirect_now;
        inst_sram_addr_ok = $urandom % 3 != 0;
        if (req_due_q.size() > 0 && req_due_q[0] <= cycle) begin
            inst_sram_data_ok = 1'b1;
            inst_sram_rdata   = word_at(req_addr_q[0]);
        end else begin
            inst_sram_data_ok = 1'b0;
            inst_sram_rdata   = 32'h0;
        end
    endtask

    initial begin
        void'($urandom(32'h9f4a));
        clk               = 1'b0;
        reset             = 1'b1;
        ds_allowin        = 1'b0;
        eret              = 1'b0;
        ex_word           = 4'h0;
        br                = 1'b0;
        br_stall          = 1'b0;
        br_taken          = 1'b0;
        br_target         = 32'h0;
        cp0_epc           = 32'h0;
        inst_sram_addr_ok = 1'b0;
        inst_sram_data_ok = 1'b0;
        inst_sram_rdata   = 32'h0;
        cycle             = 0;
        in_flight         = 0;
        delivered         = 0;
        idle_cycles       = 0;
        pc_errors         = 0;
        inst_errors       = 0;
        ex_errors         = 0;
        bus_errors        = 0;
        other_errors      = 0;
        exp_pc            = reset_vector;
        next_tag          = "reset_vector";
        in_slot           = 1'b0;
        br_active         = 1'b0;
        br_taken_m        = 1'b0;
        br_target_m       = 32'h0;
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
        while (delivered < target_count && idle_cycles < timeout_cycles) begin
            #36;
            sample_cycle();
            @(posedge clk);
            #2;
            drive_inputs();
        end
        if (idle_cycles >= timeout_cycles) begin
            other_errors++;
            $display("timeout: nothing delivered to decode for %0d cycles", timeout_cycles);
        end
        $display("errors: pc %0d, inst %0d, ex_code %0d, bus %0d, other %0d (delivered %0d)",
                 pc_errors, inst_errors, ex_errors, bus_errors, other_errors, delivered);
        if (pc_errors + inst_errors + ex_errors + bus_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verif
design/cpu_cfg_pkg.sv
design/fetch_pkg.sv
design/inst_req_if.sv
design/pre_decode.sv
design/if_stage.sv
design/inst_req_tracker.sv
design/fetch_top.sv
verif/tb_fetch_top.sv

//--- Makefile
# Verilator simulation of the fetch front end

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -qx ">>> PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
